//--- logic/mii_tx_pkg.sv
`default_nettype none

package mii_tx_pkg;

	// frame layout on MII, all counts in nibbles
	localparam int preamble_nibbles = 16; // fifteen 5s and the SFD
	localparam int header_nibbles   = 28; // dest, src, type
	localparam int frame_id_nibbles = 4;  // 16-bit frame counter
	localparam int fcs_nibbles      = 8;  // CRC-32

	localparam logic [3:0] preamble_nibble = 4'h5;
	localparam logic [3:0] sfd_nibble      = 4'hd; // 0xd5 byte, low nibble went first

	// buffer address width, each bank holds up to 2**addr_w nibbles
	localparam int addr_w = 6;

	typedef logic [47:0] mac_addr_t;         // station address, MSB byte first on the wire
	typedef logic [addr_w-1:0] nib_addr_t;

	// framer phases in transmit order
	typedef enum logic [2:0] {
		s_idle     = 3'd0,
		s_preamble = 3'd1,
		s_header   = 3'd2,
		s_frame_id = 3'd3,
		s_payload  = 3'd4,
		s_fcs      = 3'd5
	} tx_state_t;

	// packer -> buffer write port
	typedef struct packed {
		logic      valid;  // one nibble complete this cycle
		logic      bank;
		nib_addr_t addr;
		logic [3:0] nibble; // bit 0 arrived first
	} nib_wr_t;

	// framer -> buffer read request, data comes back a cycle later
	typedef struct packed {
		logic      bank;
		nib_addr_t addr;
	} nib_rd_t;

	// whole frame length on MII for a given payload size
	function automatic int frame_nibbles(input int payload_nibbles);
		return preamble_nibbles + header_nibbles + frame_id_nibbles +
			payload_nibbles + fcs_nibbles;
	endfunction

endpackage

`default_nettype wire

//--- logic/bit_packer.sv
`timescale 1ns/1ps
`default_nettype none

module bit_packer #(
	parameter int payload_nibbles = 64
) (
	input  wire                 ff_clk,
	input  wire                 reset,
	input  wire                 bit_valid,
	input  wire                 bit_data,
	output mii_tx_pkg::nib_wr_t nib_wr,
	output logic                bank_done
);
	import mii_tx_pkg::*;

	localparam nib_addr_t last_addr = nib_addr_t'(payload_nibbles - 1);

	logic [2:0] hold;    // first three bits of the nibble in flight
	logic [1:0] bit_cnt; // bits already held
	nib_addr_t  addr;    // next nibble slot in the bank
	logic       bank;    // bank being filled
	logic       last_nib;

	assign last_nib = (addr == last_addr);

	// the fourth bit completes the nibble combinationally
	assign nib_wr.valid  = bit_valid && (bit_cnt == 2'd3);
	assign nib_wr.bank   = bank;
	assign nib_wr.addr   = addr;
	assign nib_wr.nibble = {bit_data, hold}; // earliest bit lands in bit 0

	assign bank_done = nib_wr.valid && last_nib; // bank full with this write

	always_ff @(posedge ff_clk) begin
		if (reset) begin
			hold    <= '0;
			bit_cnt <= '0;
			addr    <= '0;
			bank    <= 1'b0;
		end else if (bit_valid) begin
			hold    <= {bit_data, hold[2:1]}; // shift in from the top
			bit_cnt <= bit_cnt + 2'd1;        // wraps after the fourth bit
			if (bit_cnt == 2'd3) begin
				if (last_nib) begin
					addr <= '0;
					bank <= ~bank; // next payload goes to the other bank
				end else begin
					addr <= addr + 1'b1;
				end
			end
		end
	end

	// the address must wrap before running past the payload
	a_addr_in_range: assert property (@(posedge ff_clk) disable iff (reset)
		addr <= last_addr)
		else $error("bit_packer address %0d beyond payload", addr);

endmodule

`default_nettype wire

//--- logic/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
	parameter int payload_nibbles = 64
) (
	input  wire                      ff_clk,
	input  wire                      reset,
	input  wire mii_tx_pkg::nib_wr_t nib_wr,
	input  wire                      bank_done,
	input  wire mii_tx_pkg::nib_rd_t rd,
	input  wire                      bank_release,
	input  wire                      bit_valid,
	output logic [3:0]               rd_nibble,
	output logic                     bank_ready,
	output logic                     ready_bank,
	output logic                     credit
);
	import mii_tx_pkg::*;

	localparam int bits_per_credit = payload_nibbles * 4;
	localparam int cnt_w = $clog2(2 * bits_per_credit + 1); // room for both credits
	localparam logic [cnt_w-1:0] credit_step = cnt_w'(bits_per_credit);

	// each bank spans the full address range, only payload_nibbles slots get used
	logic [3:0] mem [2**(addr_w+1)];

	logic [1:0]       full;        // one flag per bank
	logic             rd_ptr;      // oldest bank, banks drain in fill order
	logic [1:0]       boot_cnt;    // start-up credits already given
	logic [cnt_w-1:0] credit_bits; // bits the source may still send

	always_ff @(posedge ff_clk) begin
		if (nib_wr.valid) begin
			mem[{nib_wr.bank, nib_wr.addr}] <= nib_wr.nibble;
		end
		rd_nibble <= mem[{rd.bank, rd.addr}]; // one cycle read latency
	end

	assign bank_ready = full[rd_ptr];
	assign ready_bank = rd_ptr;

	always_ff @(posedge ff_clk) begin
		if (reset) begin
			full   <= 2'b00;
			rd_ptr <= 1'b0;
		end else begin
			if (bank_done) begin
				full[nib_wr.bank] <= 1'b1;
			end
			if (bank_release) begin
				full[rd_ptr] <= 1'b0; // framer is done reading it
				rd_ptr       <= ~rd_ptr;
			end
		end
	end

	// two credits straight after reset, then one per freed bank
	always_ff @(posedge ff_clk) begin
		if (reset) begin
			boot_cnt <= '0;
			credit   <= 1'b0;
		end else begin
			if (boot_cnt != 2'd2) begin
				boot_cnt <= boot_cnt + 2'd1;
			end
			credit <= (boot_cnt != 2'd2) || bank_release;
		end
	end

	// running count of granted but unsent bits
	always_ff @(posedge ff_clk) begin
		if (reset) begin
			credit_bits <= '0;
		end else begin
			credit_bits <= credit_bits + (credit ? credit_step : '0) -
				{{(cnt_w-1){1'b0}}, bit_valid};
		end
	end

	// source must hold a credit for every bit
	a_bit_has_credit: assert property (@(posedge ff_clk) disable iff (reset)
		bit_valid |-> (credit_bits != '0))
		else $error("bit arrived without credit");

	// packer must never overwrite a bank that still waits for the framer
	a_no_write_full: assert property (@(posedge ff_clk) disable iff (reset)
		nib_wr.valid |-> !full[nib_wr.bank])
		else $error("write into full bank %0d", nib_wr.bank);

endmodule

`default_nettype wire

//--- logic/crc32_nibble.sv
`timescale 1ns/1ps
`default_nettype none

module crc32_nibble (
	input  wire        ff_clk,
	input  wire        reset,
	input  wire        crc_init,
	input  wire        crc_en,
	input  wire [3:0]  crc_nibble,
	output logic [31:0] crc
);

	localparam logic [31:0] poly = 32'hedb88320; // reflected 802.3 polynomial

	// four serial steps with bit 0 of the nibble first as on the wire
	function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [3:0] d);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 4; i++) begin
			if (r[0] ^ d[i]) begin
				r = (r >> 1) ^ poly;
			end else begin
				r = r >> 1;
			end
		end
		return r;
	endfunction

	always_ff @(posedge ff_clk) begin
		if (reset) begin
			crc <= '1;
		end else if (crc_init) begin
			crc <= '1; // preset per frame
		end else if (crc_en) begin
			crc <= crc_step(crc, crc_nibble);
		end
	end

	// init and enable come from different framer phases
	a_init_en_excl: assert property (@(posedge ff_clk) disable iff (reset)
		!(crc_init && crc_en))
		else $error("crc_init and crc_en together");

endmodule

`default_nettype wire

//--- logic/mii_framer.sv
`timescale 1ns/1ps
`default_nettype none

module mii_framer #(
	parameter int                    payload_nibbles = 64,
	parameter mii_tx_pkg::mac_addr_t dest_addr       = 48'hffff_ffff_ffff,
	parameter mii_tx_pkg::mac_addr_t src_addr        = 48'h0200_0000_0001
) (
	input  wire                 ff_clk,
	input  wire                 reset,
	input  wire                 bank_ready,
	input  wire                 ready_bank,
	input  wire [3:0]           rd_nibble,
	input  wire [31:0]          crc,
	output mii_tx_pkg::nib_rd_t rd,
	output logic                bank_release,
	output logic                crc_init,
	output logic                crc_en,
	output logic [3:0]          crc_nibble,
	output logic [3:0]          tx_d,
	output logic                tx_en,
	output logic                tx_er
);
	import mii_tx_pkg::*;

	localparam int frame_len = frame_nibbles(payload_nibbles);
	localparam int run_w = $clog2(frame_len + 1);

	tx_state_t  state;
	nib_addr_t  idx;       // nibble within the current phase
	nib_addr_t  last_idx;
	logic [15:0] frame_id; // counts sent frames
	logic [4*header_nibbles-1:0] hdr; // header in wire order, next nibble at the bottom
	logic [3:0] next_d;    // nibble for tx_d in the next cycle
	logic [run_w-1:0] tx_run;

	// MSB byte moves to the bottom so a right shift walks the bytes in order
	function automatic logic [47:0] wire_order(input mac_addr_t a);
		logic [47:0] r;
		for (int b = 0; b < 6; b++) begin
			r[8*b +: 8] = a[47-8*b -: 8];
		end
		return r;
	endfunction

	always_comb begin
		case (state)
			s_preamble: last_idx = nib_addr_t'(preamble_nibbles - 1);
			s_header:   last_idx = nib_addr_t'(header_nibbles - 1);
			s_frame_id: last_idx = nib_addr_t'(frame_id_nibbles - 1);
			s_payload:  last_idx = nib_addr_t'(payload_nibbles - 1);
			s_fcs:      last_idx = nib_addr_t'(fcs_nibbles - 1);
			default:    last_idx = '0;
		endcase
	end

	always_comb begin
		case (state)
			s_preamble: next_d = (idx == last_idx) ? sfd_nibble : preamble_nibble;
			s_header:   next_d = hdr[3:0];
			s_frame_id: next_d = frame_id[{idx[1:0], 2'b00} +: 4]; // low nibble first
			s_payload:  next_d = rd_nibble;                        // read issued last cycle
			s_fcs:      next_d = ~crc[{idx[2:0], 2'b00} +: 4];
			default:    next_d = 4'h0;
		endcase
	end

	// buffer read runs one nibble ahead of the payload phase
	assign rd.bank = ready_bank; // pointer only moves on release
	assign rd.addr = (state == s_payload) ? idx + 1'b1 : '0;

	assign bank_release = (state == s_payload) && (idx == last_idx); // last nibble is in
	assign crc_init     = (state == s_preamble);
	assign crc_en       = (state == s_header) || (state == s_frame_id) ||
		(state == s_payload);
	assign crc_nibble   = next_d; // CRC sees exactly what goes out
	assign tx_er        = 1'b0;   // never signal a coding error

	always_ff @(posedge ff_clk) begin
		if (reset) begin
			state    <= s_idle;
			idx      <= '0;
			frame_id <= '0;
		end else if (state == s_idle) begin
			idx <= '0;
			if (bank_ready) begin
				state <= s_preamble;
			end
		end else if (idx == last_idx) begin
			idx <= '0;
			case (state)
				s_preamble: state <= s_header;
				s_header:   state <= s_frame_id;
				s_frame_id: state <= s_payload;
				s_payload:  state <= s_fcs;
				default: begin
					state    <= s_idle; // single idle cycle between frames
					frame_id <= frame_id + 16'd1;
				end
			endcase
		end else begin
			idx <= idx + 1'b1;
		end
	end

	// addresses are fixed, reload while idle and shift during the header
	always_ff @(posedge ff_clk) begin
		if (state == s_idle) begin
			hdr <= {16'h0000, wire_order(src_addr), wire_order(dest_addr)}; // type is zero
		end else if (state == s_header) begin
			hdr <= hdr >> 4;
		end
	end

	// MII outputs registered, tx_en trails the state by one cycle
	always_ff @(posedge ff_clk) begin
		if (reset) begin
			tx_d  <= 4'h0;
			tx_en <= 1'b0;
		end else begin
			tx_d  <= next_d;
			tx_en <= (state != s_idle);
		end
	end

	always_ff @(posedge ff_clk) begin
		if (reset || !tx_en) begin
			tx_run <= '0;
		end else begin
			tx_run <= tx_run + 1'b1;
		end
	end

	// one burst never runs past a full frame
	a_tx_en_len: assert property (@(posedge ff_clk) disable iff (reset)
		tx_en |-> (tx_run < run_w'(frame_len)))
		else $error("tx_en high longer than %0d nibbles", frame_len);

endmodule

`default_nettype wire

//--- logic/mii_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module mii_tx_top #(
	parameter int                    payload_nibbles = 64,
	parameter mii_tx_pkg::mac_addr_t dest_addr       = 48'hffff_ffff_ffff,
	parameter mii_tx_pkg::mac_addr_t src_addr        = 48'h0200_0000_0001
) (
	input  wire        ff_clk,
	input  wire        reset,
	input  wire        bit_valid,
	input  wire        bit_data,
	output logic       credit,
	output logic [3:0] tx_d,
	output logic       tx_en,
	output logic       tx_er
);
	import mii_tx_pkg::*;

	nib_wr_t     nib_wr;
	nib_rd_t     rd;
	logic        bank_done;
	logic        bank_release;
	logic        bank_ready;
	logic        ready_bank;
	logic [3:0]  rd_nibble;
	logic        crc_init;
	logic        crc_en;
	logic [3:0]  crc_nibble;
	logic [31:0] crc;

	bit_packer #(
		.payload_nibbles(payload_nibbles)
	) i_bit_packer (
		.ff_clk    (ff_clk),
		.reset     (reset),
		.bit_valid (bit_valid),
		.bit_data  (bit_data),
		.nib_wr    (nib_wr),
		.bank_done (bank_done)
	);

	frame_buffer #(
		.payload_nibbles(payload_nibbles)
	) i_frame_buffer (
		.ff_clk       (ff_clk),
		.reset        (reset),
		.nib_wr       (nib_wr),
		.bank_done    (bank_done),
		.rd           (rd),
		.bank_release (bank_release),
		.bit_valid    (bit_valid),    // for credit bookkeeping
		.rd_nibble    (rd_nibble),
		.bank_ready   (bank_ready),
		.ready_bank   (ready_bank),
		.credit       (credit)
	);

	crc32_nibble i_crc32_nibble (
		.ff_clk     (ff_clk),
		.reset      (reset),
		.crc_init   (crc_init),
		.crc_en     (crc_en),
		.crc_nibble (crc_nibble),
		.crc        (crc)
	);

	mii_framer #(
		.payload_nibbles (payload_nibbles),
		.dest_addr       (dest_addr),
		.src_addr        (src_addr)
	) i_mii_framer (
		.ff_clk       (ff_clk),
		.reset        (reset),
		.bank_ready   (bank_ready),
		.ready_bank   (ready_bank),
		.rd_nibble    (rd_nibble),
		.crc          (crc),
		.rd           (rd),
		.bank_release (bank_release),
		.crc_init     (crc_init),
		.crc_en       (crc_en),
		.crc_nibble   (crc_nibble),
		.tx_d         (tx_d),
		.tx_en        (tx_en),
		.tx_er        (tx_er)
	);

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic ff_clk,
	output logic reset
);

	initial begin
		ff_clk = 1'b0;
		forever #50 ff_clk = ~ff_clk; // 100 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (5) @(posedge ff_clk);
		reset <= 1'b0; // released on the edge like any other input
	end

endmodule

`default_nettype wire

//--- testbench/mii_tx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mii_tx_tb;

	localparam int payload_nibbles = 16;
	localparam int payload_bits = payload_nibbles * 4;
	localparam int frame_len = 16 + 28 + 4 + payload_nibbles + 8;
	localparam logic [47:0] dest_addr = 48'h02aa_bb01_0203;
	localparam logic [47:0] src_addr = 48'h0211_2233_4455;
	localparam int n_frames = 10; // frames over all tests including the cut one
	localparam int timeout_cycles =
		4 * (n_frames * (frame_len + 1) + n_frames * 2 * payload_bits + 6 * 20);

	logic ff_clk;
	logic clk_reset;
	logic tb_reset = 1'b0;
	logic reset;
	logic bit_valid = 1'b0;
	logic bit_data = 1'b0;
	logic credit;
	logic [3:0] tx_d;
	logic tx_en;
	logic tx_er;

	assign reset = clk_reset | tb_reset; // start-up reset or a test's own

	tb_clock i_tb_clock (
		.ff_clk (ff_clk),
		.reset  (clk_reset)
	);

	mii_tx_top #(
		.payload_nibbles (payload_nibbles),
		.dest_addr       (dest_addr),
		.src_addr        (src_addr)
	) i_mii_tx_top (
		.ff_clk    (ff_clk),
		.reset     (reset),
		.bit_valid (bit_valid),
		.bit_data  (bit_data),
		.credit    (credit),
		.tx_d      (tx_d),
		.tx_en     (tx_en),
		.tx_er     (tx_er)
	);

	logic [31:0] lfsr = 32'h92260928;
	logic src_q [$];            // bits waiting for credit
	logic gap_mode = 1'b0;      // idle cycle after every bit
	logic [3:0] exp_payload [3][payload_nibbles];
	logic [3:0] cap [8][128];   // captured tx_en bursts
	int cap_len [8];
	int cap_count = 0;
	logic [3:0] exp_frame [128];
	int exp_len = 0;
	int credits_seen = 0;       // pulses since reset
	int avail_bits = 0;         // source's unused credit
	int bits_sent = 0;
	int frames_started = 0;
	int cur_len = 0;
	logic in_frame = 1'b0;
	logic c3_seen = 1'b0;       // state when the third credit came
	logic c3_in_frame = 1'b0;
	int c3_frames = 0;
	int c3_bits = 0;
	int cycles = 0;

	// taps 32,22,2,1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// bit-serial 802.3 CRC over exp_frame[first..last] with bit 0 of each nibble first
	function automatic logic [31:0] crc_ref(input int first, input int last);
		logic [31:0] c;
		logic fb;
		c = 32'hffff_ffff;
		for (int n = first; n <= last; n++) begin
			for (int b = 0; b < 4; b++) begin
				fb = c[0] ^ exp_frame[n][b];
				c = c >> 1;
				if (fb) c = c ^ 32'hedb8_8320;
			end
		end
		return c;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp_v,
		input logic [31:0] got_v);
		$display("FAIL %s expected %h got %h", name, exp_v, got_v);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic report_error(input string what);
		$display("error: %s", what);
		$display("** FAIL **");
		$fatal(1);
	endtask

	// samples outputs before the edge updates them and drives the source
	always @(posedge ff_clk) begin
		if (reset) begin
			credits_seen = 0;
			avail_bits = 0;
			bits_sent = 0;
			frames_started = 0;
			in_frame = 1'b0;
			cur_len = 0;
			cap_count = 0;
			c3_seen = 1'b0;
			src_q.delete();
			bit_valid <= 1'b0;
			bit_data <= 1'b0;
		end else begin
			assert (tx_er == 1'b0) else report_mismatch("tx_er", 0, tx_er);
			if (credit) begin
				credits_seen++;
				avail_bits += payload_bits; // one payload per pulse
				if (credits_seen == 3) begin
					c3_seen = 1'b1;
					c3_in_frame = in_frame;
					c3_frames = cap_count;
					c3_bits = bits_sent;
				end
			end
			if (tx_en) begin
				if (!in_frame) begin
					// a frame may only start once its whole payload is in
					assert (bits_sent >= payload_bits * (frames_started + 1))
						else report_error("tx_en rose before a full payload arrived");
					in_frame = 1'b1;
					cur_len = 0;
					frames_started++;
				end
				assert (cur_len < 128) else report_error("tx_en burst too long");
				assert (cap_count < 8) else report_error("too many frames captured");
				cap[cap_count][cur_len] = tx_d;
				cur_len++;
			end else if (in_frame) begin
				in_frame = 1'b0;
				cap_len[cap_count] = cur_len;
				cap_count++;
			end
			if (src_q.size() > 0 && avail_bits > 0 && !(gap_mode && bit_valid)) begin
				bit_valid <= 1'b1;
				bit_data <= src_q.pop_front();
				avail_bits--;
				bits_sent++;
			end else begin
				bit_valid <= 1'b0;
			end
		end
	end

	always @(posedge ff_clk) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("error: run did not finish within %0d cycles", timeout_cycles);
			$display("** FAIL **");
			$fatal(1);
		end
	end

	task automatic do_reset;
		@(posedge ff_clk);
		tb_reset <= 1'b1;
		repeat (3) @(posedge ff_clk);
		tb_reset <= 1'b0;
		@(negedge ff_clk);
	endtask

	// one payload from the LFSR into the source queue and the model
	task automatic push_payload(input int p);
		logic [3:0] nib;
		for (int n = 0; n < payload_nibbles; n++) begin
			for (int b = 0; b < 4; b++) begin
				nib[b] = lfsr[31];
				src_q.push_back(lfsr[31]);
				lfsr = lfsr_step(lfsr);
			end
			exp_payload[p][n] = nib;
		end
	endtask

	task automatic wait_frames(input int n);
		while (cap_count < n) @(negedge ff_clk);
	endtask

	task automatic build_frame(input logic [15:0] id, input int p);
		logic [7:0] byte_v;
		logic [31:0] fcs;
		exp_len = 0;
		for (int i = 0; i < 16; i++) begin
			exp_frame[exp_len++] = (i == 15) ? 4'hd : 4'h5; // SFD last
		end
		for (int i = 0; i < 12; i++) begin
			byte_v = (i < 6) ? dest_addr[47-8*i -: 8] : src_addr[47-8*(i-6) -: 8];
			exp_frame[exp_len++] = byte_v[3:0]; // low nibble first
			exp_frame[exp_len++] = byte_v[7:4];
		end
		for (int i = 0; i < 4; i++) exp_frame[exp_len++] = 4'h0; // type
		for (int i = 0; i < 4; i++) exp_frame[exp_len++] = id[4*i +: 4];
		for (int i = 0; i < payload_nibbles; i++) exp_frame[exp_len++] = exp_payload[p][i];
		fcs = ~crc_ref(16, exp_len - 1);
		for (int i = 0; i < 8; i++) exp_frame[exp_len++] = fcs[4*i +: 4];
	endtask

	task automatic check_frame(input int k, input logic [15:0] id, input int p);
		string name;
		build_frame(id, p);
		assert (cap_len[k] == exp_len)
			else report_mismatch("frame length", exp_len, cap_len[k]);
		for (int i = 0; i < exp_len; i++) begin
			if (i < 16) name = $sformatf("tx_d preamble[%0d]", i);
			else if (i < 44) name = $sformatf("tx_d header[%0d]", i - 16);
			else if (i < 48) name = $sformatf("tx_d frame_id[%0d]", i - 44);
			else if (i < exp_len - 8) name = $sformatf("tx_d payload[%0d]", i - 48);
			else name = $sformatf("tx_d fcs[%0d]", i - (exp_len - 8));
			assert (cap[k][i] == exp_frame[i])
				else report_mismatch(name, exp_frame[i], cap[k][i]);
		end
	endtask

	task automatic credits_after_reset;
		do_reset();
		repeat (10) @(negedge ff_clk);
		assert (credits_seen == 2) else report_mismatch("credit pulses", 2, credits_seen);
		push_payload(0);
		void'(src_q.pop_back()); // hold back the last bit
		while (bits_sent < payload_bits - 1) @(negedge ff_clk);
		repeat (20) @(negedge ff_clk);
		assert (frames_started == 0) else report_error("tx_en rose with payload incomplete");
		src_q.push_back(exp_payload[0][payload_nibbles-1][3]);
		wait_frames(1);
		check_frame(0, 16'd0, 0);
	endtask

	task automatic single_frame_layout;
		do_reset();
		push_payload(0);
		wait_frames(1);
		check_frame(0, 16'd0, 0); // FCS included
	endtask

	task automatic gapped_stream_fcs;
		do_reset();
		gap_mode = 1'b1;
		push_payload(0);
		wait_frames(1);
		check_frame(0, 16'd0, 0);
		gap_mode = 1'b0;
	endtask

	task automatic back_to_back_frames;
		do_reset();
		for (int p = 0; p < 3; p++) push_payload(p);
		wait_frames(3);
		for (int k = 0; k < 3; k++) check_frame(k, 16'(k), k);
		assert (credits_seen == 5) else report_mismatch("credit pulses", 5, credits_seen);
	endtask

	task automatic credit_back_pressure;
		do_reset();
		for (int p = 0; p < 3; p++) push_payload(p);
		wait_frames(3);
		assert (c3_seen) else report_error("third credit never came");
		// the source must sit on two payloads until the first frame frees a bank
		assert (c3_bits == 2 * payload_bits) else report_mismatch("bits before credit",
			2 * payload_bits, c3_bits);
		assert (c3_in_frame && c3_frames == 0)
			else report_error("third credit came outside the first frame");
		for (int k = 0; k < 3; k++) check_frame(k, 16'(k), k);
	endtask

	task automatic reset_during_frame;
		do_reset();
		push_payload(0);
		while (!(in_frame && cur_len >= 20)) @(negedge ff_clk);
		@(posedge ff_clk);
		tb_reset <= 1'b1;
		@(posedge ff_clk);
		@(negedge ff_clk); // first cycle with reset applied
		assert (tx_en == 1'b0) else report_mismatch("tx_en", 0, tx_en);
		assert (tx_d == 4'h0) else report_mismatch("tx_d", 0, tx_d);
		repeat (2) @(posedge ff_clk);
		tb_reset <= 1'b0;
		repeat (6) @(negedge ff_clk);
		assert (credits_seen == 2) else report_mismatch("credit pulses", 2, credits_seen);
		assert (cap_count == 0) else report_error("cut frame was reported as complete");
		push_payload(0);
		wait_frames(1);
		check_frame(0, 16'd0, 0); // frame counter restarted
	endtask

	initial begin
		@(negedge clk_reset);
		credits_after_reset();
		single_frame_layout();
		gapped_stream_fcs();
		back_to_back_frames();
		credit_back_pressure();
		reset_during_frame();
		repeat (2) @(negedge ff_clk);
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
logic/mii_tx_pkg.sv
logic/bit_packer.sv
logic/frame_buffer.sv
logic/crc32_nibble.sv
logic/mii_framer.sv
logic/mii_tx_top.sv
testbench/tb_clock.sv
testbench/mii_tx_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module mii_tx_tb -Mdir obj_dir -o mii_tx_sim
	./obj_dir/mii_tx_sim > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
